//--- source/pmbus_config.svh
`ifndef PMBUS_CONFIG_SVH
`define PMBUS_CONFIG_SVH

// ******************************
// command codes
// ******************************
`define CMD_READ_VOUT          8'h8B  // telemetry reads
`define CMD_READ_IOUT          8'h8C
`define CMD_READ_TMP           8'h8D
`define CMD_READ_VIN           8'h88

`define CMD_STATUS_BYTE        8'h78  // status reads, the per-source ones also clear
`define CMD_STATUS_VOUT        8'h7A
`define CMD_STATUS_IOUT        8'h7B
`define CMD_STATUS_INPUT       8'h7C
`define CMD_STATUS_TEMPERATURE 8'h7D
`define CMD_STATUS_CML         8'h7E

`define CMD_VOUT_COMMAND       8'h21  // program output voltage code
`define CMD_SMBALERT_MASK      8'h1B  // ldb names the status register, hdb carries mask bits
`define CMD_CLEAR_FAULTS       8'h03  // no data bytes

// alert response address, 7 bit
`define ALERT_RESP_ADDR        7'h0C

// highest legal vid code
`define VOUT_MAX               8'd250

// ******************************
// falling-edge count positions
// ******************************
`define CNT_READ_LOAD          6'd9   // read data goes out after the address byte
`define CNT_CMD_DONE           6'd18
`define CNT_LDB_DONE           6'd27
`define CNT_HDB_DONE           6'd36
`define CNT_WRITE_LIMIT        6'd38  // reaching this while writing means an extra byte
`define CNT_READ_LIMIT         6'd28  // passing this while reading means an extra byte

`endif

//--- source/pmbusPkg.sv
package pmbusPkg;

	// one bus data byte
	typedef logic [7:0] pmByte_t;

	// falling scl edge counter from the bus engine
	typedef logic [5:0] bitCount_t;

	// 7-bit slave address without the r/w bit
	typedef logic [6:0] devAddr_t;

	// STATUS_BYTE layout, msb first
	typedef struct packed {
		logic rsvd7;    // busy, not implemented
		logic unitOff;
		logic voutOv;
		logic ioutOc;
		logic vinUv;
		logic tmpOv;
		logic cml;      // any communication fault
		logic rsvd0;    // none of the above, not implemented
	} statusByte_t;

endpackage

//--- source/busEventIf.sv
`timescale 1ns/1ps

// transaction view handed over by the byte-level bus engine
interface busEventIf import pmbusPkg::*; ();
	pmByte_t   cmd;     // command code
	pmByte_t   ldb;     // low data byte
	pmByte_t   hdb;     // high data byte
	pmByte_t   addr;    // address byte, bit 0 is r/w
	logic      rwBit;
	logic      start;   // one-cycle pulse
	logic      stop;    // one-cycle pulse
	logic      rStart;  // repeated start seen
	logic      dBusy;   // transfer in progress
	bitCount_t count;

	modport consumer (input cmd, ldb, hdb, addr, rwBit, start, stop, rStart, dBusy, count);
endinterface

// communication fault flags from the protocol checker
interface commFaultIf ();
	logic cmdFault;   // unsupported command
	logic dataFault;  // bad mask target, vid out of range or too many bytes written
	logic xferFault;  // too many bytes read, too few bits or bad read bit
	logic cmlBit;     // registered or of all flags
	logic badRead;    // read bit without repeated start
	logic ldbBad;     // low byte detail for the top-level ldbV
	logic hdbBad;     // high byte detail for the top-level hdbV

	modport source (output cmdFault, dataFault, xferFault, cmlBit, badRead, ldbBad, hdbBad);
	modport sink (input cmdFault, dataFault, xferFault, cmlBit, badRead);
endinterface

//--- source/protocolChecker.sv
`timescale 1ns/1ps
`include "pmbus_config.svh"

module protocolChecker import pmbusPkg::*; (
	input logic         clk,
	input logic         rst,
	busEventIf.consumer bus,
	commFaultIf.source  fault
);

	devAddr_t busAddr;
	logic     araXfer;      // alert response read, skips cmd and read bit checks
	logic     cmdKnown;
	logic     maskTargetOk;
	logic     partialByte;  // count stopped inside a byte
	logic     endsXfer;

	logic cmdBad;
	logic ldbBad;
	logic hdbBad;
	logic tooManyWr;
	logic tooManyRd;
	logic tooFewBits;
	logic badRead;
	logic anyFlag;
	logic cmlReg;

	assign busAddr = bus.addr[7:1];
	assign araXfer = (busAddr == `ALERT_RESP_ADDR);
	assign endsXfer = bus.start || bus.stop;

	assign cmdKnown = bus.cmd inside {`CMD_READ_VOUT, `CMD_READ_IOUT, `CMD_READ_TMP,
		`CMD_READ_VIN, `CMD_STATUS_BYTE, `CMD_STATUS_VOUT, `CMD_STATUS_IOUT,
		`CMD_STATUS_INPUT, `CMD_STATUS_TEMPERATURE, `CMD_STATUS_CML,
		`CMD_VOUT_COMMAND, `CMD_SMBALERT_MASK, `CMD_CLEAR_FAULTS};

	// mask writes may only target the per-source status registers
	assign maskTargetOk = bus.ldb inside {`CMD_STATUS_VOUT, `CMD_STATUS_IOUT,
		`CMD_STATUS_INPUT, `CMD_STATUS_TEMPERATURE, `CMD_STATUS_CML};

	// ack bit positions are 9, 18, 27 and 36, anything between them is partial
	assign partialByte =
		(bus.count > 6'd1 && bus.count < `CNT_READ_LOAD) ||
		(bus.count > (`CNT_READ_LOAD + 6'd1) && bus.count < `CNT_CMD_DONE) ||
		(bus.count > (`CNT_CMD_DONE + 6'd1) && bus.count < `CNT_LDB_DONE) ||
		(bus.count > (`CNT_LDB_DONE + 6'd1) && bus.count < `CNT_HDB_DONE);

	// ******************************
	// fault flags
	// ******************************
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cmdBad     <= 1'b0;
			ldbBad     <= 1'b0;
			hdbBad     <= 1'b0;
			tooManyWr  <= 1'b0;
			tooManyRd  <= 1'b0;
			tooFewBits <= 1'b0;
			badRead    <= 1'b0;
		end
		else
		begin
			if (endsXfer)
				cmdBad <= 1'b0;
			else if (bus.count == `CNT_CMD_DONE && !araXfer)
				cmdBad <= !cmdKnown;  // judged once the command byte is in

			if (bus.count == `CNT_LDB_DONE && bus.cmd == `CMD_SMBALERT_MASK && !maskTargetOk)
				ldbBad <= 1'b1;
			else if (endsXfer)
				ldbBad <= 1'b0;

			if (bus.count == `CNT_HDB_DONE && bus.cmd == `CMD_VOUT_COMMAND && bus.hdb > `VOUT_MAX)
				hdbBad <= 1'b1;  // vid out of range
			else if (endsXfer)
				hdbBad <= 1'b0;

			if (bus.count >= `CNT_WRITE_LIMIT && !bus.rwBit)
				tooManyWr <= 1'b1;
			else if (endsXfer)
				tooManyWr <= 1'b0;

			if (bus.count > `CNT_READ_LIMIT && bus.rwBit)
				tooManyRd <= 1'b1;
			else if (endsXfer)
				tooManyRd <= 1'b0;

			// a bad read already explains the early stop
			if (bus.stop && !badRead && partialByte)
				tooFewBits <= 1'b1;
			else if (endsXfer)
				tooFewBits <= 1'b0;

			if (bus.rwBit && !bus.rStart && bus.dBusy && bus.count >= `CNT_READ_LOAD && !araXfer)
				badRead <= 1'b1;
			else if (endsXfer)
				badRead <= 1'b0;
		end
	end

	assign anyFlag = cmdBad || ldbBad || hdbBad || tooManyWr || tooManyRd || tooFewBits || badRead;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cmlReg <= 1'b0;
		else
			cmlReg <= anyFlag;
	end

	assign fault.cmdFault  = cmdBad;
	assign fault.dataFault = ldbBad || hdbBad || tooManyWr;
	assign fault.xferFault = tooManyRd || tooFewBits || badRead;
	assign fault.badRead   = badRead;
	assign fault.cmlBit    = cmlReg;
	assign fault.ldbBad    = ldbBad;
	assign fault.hdbBad    = hdbBad;

	// cml follows the flags with one cycle of delay
	cmlNeedsFlag: assert property (@(posedge clk) disable iff (!rst)
		$rose(cmlReg) |-> $past(anyFlag));

endmodule

//--- source/faultTracker.sv
`timescale 1ns/1ps

module faultTracker (
	input  logic clk,
	input  logic rst,
	input  logic set,        // fault condition, level
	input  logic clr,        // registered clear pulse
	input  logic maskLoad,
	input  logic maskValue,
	output logic status,     // sticky status bit
	output logic alertReq    // one-cycle alert request
);

	logic setPrev;  // for the rising edge of set
	logic mask;     // 1 keeps this channel off the alert line

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			status   <= 1'b0;
			setPrev  <= 1'b0;
			mask     <= 1'b0;
			alertReq <= 1'b0;
		end
		else
		begin
			if (set)
				status <= 1'b1;  // set wins over a clear in the same cycle
			else if (clr)
				status <= 1'b0;

			if (maskLoad)
				mask <= maskValue;

			setPrev  <= set;
			alertReq <= set && !setPrev && !mask;
		end
	end

	// a fault still present keeps its status bit through any clear
	statusHeld: assert property (@(posedge clk) disable iff (!rst)
		set |=> status);

endmodule

//--- source/faultBank.sv
`timescale 1ns/1ps
`include "pmbus_config.svh"

module faultBank import pmbusPkg::*; (
	input  logic        clk,
	input  logic        rst,
	busEventIf.consumer bus,
	commFaultIf.sink    fault,
	input  logic        voutOv,
	input  logic        ioutOc,
	input  logic        vinUv,
	input  logic        tmpOv,
	input  logic        unitOff,
	input  logic        smbalClr,    // host has serviced the alert
	output statusByte_t status,
	output logic [2:0]  cmlDetail,   // cmd, data, xfer status bits
	output logic        smbAlert
);

	// channel order
	localparam int VOUT_CH = 0;
	localparam int IOUT_CH = 1;
	localparam int VIN_CH  = 2;
	localparam int TMP_CH  = 3;
	localparam int CMD_CH  = 4;
	localparam int DATA_CH = 5;
	localparam int XFER_CH = 6;
	localparam int NUM_CH  = 7;

	logic [NUM_CH-1:0] setIn;
	logic [NUM_CH-1:0] clrNext;
	logic [NUM_CH-1:0] clrPulse;
	logic [NUM_CH-1:0] maskLoad;
	logic [NUM_CH-1:0] maskValue;
	logic [NUM_CH-1:0] chStatus;
	logic [NUM_CH-1:0] alertReq;

	logic analogOk;     // clean write at stop
	logic clearAnalog;
	logic clearCml;
	logic maskWrite;

	assign setIn = {fault.xferFault, fault.dataFault, fault.cmdFault, tmpOv, vinUv, ioutOc, voutOv};

	// ******************************
	// clear decode, registered at stop
	// ******************************
	assign analogOk    = bus.stop && !fault.cmlBit && !bus.addr[0];
	assign clearAnalog = bus.stop && bus.cmd == `CMD_CLEAR_FAULTS && !fault.cmlBit &&
		bus.addr[7:1] != `ALERT_RESP_ADDR;
	assign clearCml    = bus.stop && bus.cmd == `CMD_CLEAR_FAULTS;

	always_comb
	begin
		clrNext[VOUT_CH] = (analogOk && bus.cmd == `CMD_STATUS_VOUT && bus.ldb[7]) || clearAnalog;
		clrNext[IOUT_CH] = (analogOk && bus.cmd == `CMD_STATUS_IOUT && bus.ldb[7]) || clearAnalog;
		clrNext[VIN_CH]  = (analogOk && bus.cmd == `CMD_STATUS_INPUT && bus.ldb[4]) || clearAnalog;
		clrNext[TMP_CH]  = (analogOk && bus.cmd == `CMD_STATUS_TEMPERATURE && bus.ldb[7]) ||
			clearAnalog;
		// cml bits clear even with a fault in the clearing transfer
		clrNext[CMD_CH]  = (bus.stop && !bus.addr[0] && bus.cmd == `CMD_STATUS_CML && bus.ldb[7]) ||
			clearCml;
		clrNext[DATA_CH] = (bus.stop && !bus.addr[0] && bus.cmd == `CMD_STATUS_CML && bus.ldb[6]) ||
			clearCml;
		clrNext[XFER_CH] = (bus.stop && !bus.addr[0] && bus.cmd == `CMD_STATUS_CML && bus.ldb[1]) ||
			clearCml;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			clrPulse <= '0;
		else
			clrPulse <= clrNext;
	end

	// ******************************
	// alert mask decode
	// ******************************
	assign maskWrite = bus.stop && bus.cmd == `CMD_SMBALERT_MASK && !fault.cmlBit;

	always_comb
	begin
		maskLoad[VOUT_CH]  = maskWrite && bus.ldb == `CMD_STATUS_VOUT;
		maskLoad[IOUT_CH]  = maskWrite && bus.ldb == `CMD_STATUS_IOUT;
		maskLoad[VIN_CH]   = maskWrite && bus.ldb == `CMD_STATUS_INPUT;
		maskLoad[TMP_CH]   = maskWrite && bus.ldb == `CMD_STATUS_TEMPERATURE;
		maskLoad[CMD_CH]   = maskWrite && bus.ldb == `CMD_STATUS_CML;
		maskLoad[DATA_CH]  = maskLoad[CMD_CH];
		maskLoad[XFER_CH]  = maskLoad[CMD_CH];
		maskValue[VOUT_CH] = bus.hdb[7];
		maskValue[IOUT_CH] = bus.hdb[7];
		maskValue[VIN_CH]  = bus.hdb[4];  // input uv sits at bit 4
		maskValue[TMP_CH]  = bus.hdb[7];
		maskValue[CMD_CH]  = bus.hdb[7];
		maskValue[DATA_CH] = bus.hdb[6];
		maskValue[XFER_CH] = bus.hdb[1];
	end

	for (genvar i = 0; i < NUM_CH; i++)
	begin : gChan
		faultTracker tracker_i (
			.clk       (clk),
			.rst       (rst),
			.set       (setIn[i]),
			.clr       (clrPulse[i]),
			.maskLoad  (maskLoad[i]),
			.maskValue (maskValue[i]),
			.status    (chStatus[i]),
			.alertReq  (alertReq[i])
		);
	end

	assign cmlDetail = {chStatus[CMD_CH], chStatus[DATA_CH], chStatus[XFER_CH]};

	// ******************************
	// status byte and alert latch
	// ******************************
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			status   <= '0;
			smbAlert <= 1'b0;
		end
		else
		begin
			status.rsvd7   <= 1'b0;
			status.unitOff <= unitOff;
			status.voutOv  <= chStatus[VOUT_CH];
			status.ioutOc  <= chStatus[IOUT_CH];
			status.vinUv   <= chStatus[VIN_CH];
			status.tmpOv   <= chStatus[TMP_CH];
			status.cml     <= |cmlDetail;
			status.rsvd0   <= 1'b0;

			if (|alertReq && !smbalClr)
				smbAlert <= 1'b1;
			else if (smbalClr)
				smbAlert <= 1'b0;  // held until the host clears it
		end
	end

endmodule

//--- source/responseRegs.sv
`timescale 1ns/1ps
`include "pmbus_config.svh"

module responseRegs import pmbusPkg::*; (
	input  logic        clk,
	input  logic        rst,
	busEventIf.consumer bus,
	commFaultIf.sink    fault,
	input  pmByte_t     vout,
	input  pmByte_t     iout,
	input  pmByte_t     tmp,
	input  pmByte_t     vin,
	input  statusByte_t status,
	input  logic [2:0]  cmlDetail,  // cmd, data, xfer
	output pmByte_t     vid,
	output pmByte_t     ldbW,
	output pmByte_t     hdbW
);

	pmByte_t voutHold;
	pmByte_t ioutHold;
	pmByte_t tmpHold;
	pmByte_t vinHold;
	logic    readLoad;
	logic    vidWrite;

	assign readLoad = (bus.count == `CNT_READ_LOAD) && bus.rwBit;
	assign vidWrite = bus.stop && bus.cmd == `CMD_VOUT_COMMAND && !fault.cmlBit &&
		bus.hdb <= `VOUT_MAX;

	// ******************************
	// telemetry snapshot
	// ******************************
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			voutHold <= '0;
			ioutHold <= '0;
			tmpHold  <= '0;
			vinHold  <= '0;
		end
		else if (!bus.dBusy)  // frozen while a transfer runs
		begin
			voutHold <= vout;
			ioutHold <= iout;
			tmpHold  <= tmp;
			vinHold  <= vin;
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			vid <= '0;
		else if (vidWrite)
			vid <= bus.hdb;
	end

	// ******************************
	// read response
	// ******************************
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			ldbW <= 8'hFF;
			hdbW <= 8'hFF;
		end
		else if (fault.cmdFault || fault.badRead)
		begin
			ldbW <= 8'hFF;  // nothing valid to return
			hdbW <= 8'hFF;
		end
		else if (readLoad)
		begin
			// word reads use the high byte, status reads the low byte
			ldbW <= 8'h00;
			hdbW <= 8'hFF;
			case (bus.cmd)
				`CMD_VOUT_COMMAND: hdbW <= vid;
				`CMD_READ_VOUT:    hdbW <= voutHold;
				`CMD_READ_IOUT:    hdbW <= ioutHold;
				`CMD_READ_TMP:     hdbW <= tmpHold;
				`CMD_READ_VIN:     hdbW <= vinHold;
				`CMD_STATUS_BYTE:        ldbW <= status;
				`CMD_STATUS_VOUT:        ldbW <= {status.voutOv, 7'b0000000};
				`CMD_STATUS_IOUT:        ldbW <= {status.ioutOc, 7'b0000000};
				`CMD_STATUS_INPUT:       ldbW <= {3'b000, status.vinUv, 4'b0000};
				`CMD_STATUS_TEMPERATURE: ldbW <= {status.tmpOv, 7'b0000000};
				`CMD_STATUS_CML:
					ldbW <= {cmlDetail[2], cmlDetail[1], 4'b0000, cmlDetail[0], 1'b0};
				default:
				begin
					ldbW <= ldbW;  // write-only codes keep the last response
					hdbW <= hdbW;
				end
			endcase
		end
	end

endmodule

//--- source/pmbusRegs.sv
`timescale 1ns/1ps

module pmbusRegs import pmbusPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  pmByte_t   cmd,
	input  pmByte_t   ldb,
	input  pmByte_t   hdb,
	input  logic      rwBit,
	input  logic      dBusy,
	input  logic      start,
	input  logic      stop,
	input  bitCount_t count,
	input  pmByte_t   vout,
	input  pmByte_t   iout,
	input  pmByte_t   tmp,
	input  pmByte_t   vin,
	input  logic      unitOff,
	input  logic      voutOv,
	input  logic      ioutOc,
	input  logic      vinUv,
	input  logic      tmpOv,
	input  logic      smbalClr,
	input  pmByte_t   addr,
	input  logic      rStart,
	output logic      cmdV,
	output logic      ldbV,
	output logic      hdbV,
	output pmByte_t   ldbW,
	output pmByte_t   hdbW,
	output pmByte_t   vid,
	output pmByte_t   statusOut,
	output logic      smbAlert,
	output logic      cmlBitOut
);

	busEventIf   busIf ();
	commFaultIf  faultIf ();
	statusByte_t statusByte;
	logic [2:0]  cmlDetail;

	// bus engine side into the bundle
	assign busIf.cmd    = cmd;
	assign busIf.ldb    = ldb;
	assign busIf.hdb    = hdb;
	assign busIf.addr   = addr;
	assign busIf.rwBit  = rwBit;
	assign busIf.start  = start;
	assign busIf.stop   = stop;
	assign busIf.rStart = rStart;
	assign busIf.dBusy  = dBusy;
	assign busIf.count  = count;

	protocolChecker checker_i (
		.clk   (clk),
		.rst   (rst),
		.bus   (busIf.consumer),
		.fault (faultIf.source)
	);

	faultBank bank_i (
		.clk       (clk),
		.rst       (rst),
		.bus       (busIf.consumer),
		.fault     (faultIf.sink),
		.voutOv    (voutOv),
		.ioutOc    (ioutOc),
		.vinUv     (vinUv),
		.tmpOv     (tmpOv),
		.unitOff   (unitOff),
		.smbalClr  (smbalClr),
		.status    (statusByte),
		.cmlDetail (cmlDetail),
		.smbAlert  (smbAlert)
	);

	responseRegs resp_i (
		.clk       (clk),
		.rst       (rst),
		.bus       (busIf.consumer),
		.fault     (faultIf.sink),
		.vout      (vout),
		.iout      (iout),
		.tmp       (tmp),
		.vin       (vin),
		.status    (statusByte),
		.cmlDetail (cmlDetail),
		.vid       (vid),
		.ldbW      (ldbW),
		.hdbW      (hdbW)
	);

	assign statusOut = statusByte;
	assign cmdV      = faultIf.cmdFault;
	assign ldbV      = faultIf.ldbBad;
	assign hdbV      = faultIf.hdbBad;
	assign cmlBitOut = faultIf.cmlBit;

endmodule

//--- bench/pmbusRegsTb.sv
`timescale 1ns/1ps
`include "pmbus_config.svh"

module pmbusRegsTb import pmbusPkg::*; ();

	localparam int      WAIT_LIMIT = 20;     // cycles allowed per wait
	localparam pmByte_t DEV_WR     = 8'h80;  // write address of slave 0x40
	localparam pmByte_t DEV_RD     = 8'h81;  // read address of slave 0x40

	logic      clk;
	logic      rst;
	pmByte_t   cmd, ldb, hdb, addr;
	logic      rwBit, dBusy, start, stop, rStart;
	bitCount_t count;
	pmByte_t   vout, iout, tmp, vin;
	logic      unitOff, voutOv, ioutOc, vinUv, tmpOv, smbalClr;
	logic      cmdV, ldbV, hdbV, smbAlert, cmlBitOut;
	pmByte_t   ldbW, hdbW, vid, statusOut;

	int   errCount;      // wrong values
	int   timeoutCount;  // waits that ran out
	logic sawCmdV, sawLdbV, sawHdbV, sawCml;  // sticky over one transaction

	pmbusRegs dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// ******************************
	// helpers
	// ******************************
	task automatic stepCycle;
		@(posedge clk);
		#2;  // outputs settled, inputs change from here
	endtask

	task automatic resetDut;
		rst = 1'b0;
		repeat (3) stepCycle;
		rst = 1'b1;
	endtask

	task automatic checkByte(input string name, input pmByte_t actual, input pmByte_t expected);
		if (actual !== expected)
		begin
			$display("ERROR %0t: %s is %h, expected %h", $time, name, actual, expected);
			errCount++;
		end
	endtask

	task automatic checkStatus(input string name, input statusByte_t actual,
		input statusByte_t expected);
		if (actual !== expected)
		begin
			$display("ERROR %0t: %s is %h, expected %h", $time, name, actual, expected);
			errCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("ERROR %0t: %s is %b, expected %b", $time, name, actual, expected);
			errCount++;
		end
	endtask

	task automatic noteFlags;
		sawCmdV = sawCmdV | cmdV;
		sawLdbV = sawLdbV | ldbV;
		sawHdbV = sawHdbV | hdbV;
		sawCml  = sawCml | cmlBitOut;
	endtask

	// start, count walk up to length, stop, two idle cycles
	task automatic busTransaction(input pmByte_t addrByte, input pmByte_t cmdByte,
		input pmByte_t ldbByte, input pmByte_t hdbByte, input logic rw, input bitCount_t length);
		sawCmdV = 1'b0;
		sawLdbV = 1'b0;
		sawHdbV = 1'b0;
		sawCml  = 1'b0;
		stepCycle;
		addr   = addrByte;
		cmd    = cmdByte;
		ldb    = ldbByte;
		hdb    = hdbByte;
		rwBit  = rw;
		rStart = rw;  // reads always come after a repeated start here
		dBusy  = 1'b1;
		start  = 1'b1;
		count  = '0;
		for (int n = 1; n <= int'(length); n++)
		begin
			stepCycle;
			noteFlags;
			start = 1'b0;
			count = bitCount_t'(n);
		end
		stepCycle;
		noteFlags;
		stop = 1'b1;  // count stays on the last value
		stepCycle;
		noteFlags;
		stop   = 1'b0;
		dBusy  = 1'b0;
		rwBit  = 1'b0;
		rStart = 1'b0;
		repeat (2)
		begin
			stepCycle;
			noteFlags;  // cml trails the flags
		end
	endtask

	task automatic waitStatusBit(input logic [2:0] idx, input logic level, input string what);
		int   cycles;
		logic found;
		cycles = 0;
		found  = (statusOut[idx] === level);
		while (!found && cycles < WAIT_LIMIT)
		begin
			stepCycle;
			cycles++;
			found = (statusOut[idx] === level);
		end
		if (!found)
		begin
			$display("timeout: %s never reached %b within %0d cycles", what, level, WAIT_LIMIT);
			timeoutCount++;
		end
	endtask

	task automatic waitAlert(input logic level);
		int   cycles;
		logic found;
		cycles = 0;
		found  = (smbAlert === level);
		while (!found && cycles < WAIT_LIMIT)
		begin
			stepCycle;
			cycles++;
			found = (smbAlert === level);
		end
		if (!found)
		begin
			$display("timeout: smbAlert never reached %b within %0d cycles", level, WAIT_LIMIT);
			timeoutCount++;
		end
	endtask

	// ******************************
	// directed tests
	// ******************************
	task automatic testBadCommand;
		busTransaction(DEV_WR, 8'h55, 8'h00, 8'h00, 1'b0, 6'd18);
		checkBit("cmdV", sawCmdV, 1'b1);
		checkBit("cmlBitOut", sawCml, 1'b1);
		// a good read first leaves zeros in both response bytes
		busTransaction(DEV_RD, `CMD_READ_VOUT, 8'h00, 8'h00, 1'b1, 6'd27);
		busTransaction(DEV_RD, 8'h55, 8'h00, 8'h00, 1'b1, 6'd27);
		checkByte("ldbW", ldbW, 8'hFF);  // no valid data for an unknown code
		checkByte("hdbW", hdbW, 8'hFF);
	endtask

	task automatic testVoutCommand;
		busTransaction(DEV_WR, `CMD_VOUT_COMMAND, 8'h00, 8'd100, 1'b0, 6'd36);
		checkByte("vid", vid, 8'd100);
		// bus engine still holds the last data byte during the read
		busTransaction(DEV_RD, `CMD_VOUT_COMMAND, 8'h00, 8'd100, 1'b1, 6'd27);
		checkByte("hdbW", hdbW, 8'd100);
		checkByte("ldbW", ldbW, 8'h00);
		busTransaction(DEV_WR, `CMD_VOUT_COMMAND, 8'h00, 8'd251, 1'b0, 6'd36);
		checkBit("hdbV", sawHdbV, 1'b1);
		checkByte("vid", vid, 8'd100);  // out of range value is dropped
	endtask

	task automatic testTelemetryFreeze;
		vout = 8'h40;
		repeat (2) stepCycle;
		dBusy = 1'b1;
		stepCycle;
		vout = 8'h99;  // must not reach the snapshot
		stepCycle;
		busTransaction(DEV_RD, `CMD_READ_VOUT, 8'h00, 8'h00, 1'b1, 6'd27);
		checkByte("hdbW", hdbW, 8'h40);
		checkByte("ldbW", ldbW, 8'h00);
	endtask

	task automatic testVoutFault;
		statusByte_t expStatus;
		expStatus        = '0;
		expStatus.voutOv = 1'b1;
		voutOv = 1'b1;  // single-cycle fault
		stepCycle;
		voutOv = 1'b0;
		waitStatusBit(3'd5, 1'b1, "statusOut bit 5");
		checkStatus("statusOut", statusByte_t'(statusOut), expStatus);
		waitAlert(1'b1);
		smbalClr = 1'b1;
		stepCycle;
		smbalClr = 1'b0;
		waitAlert(1'b0);
		busTransaction(DEV_RD, `CMD_STATUS_VOUT, 8'h00, 8'h00, 1'b1, 6'd27);
		checkByte("ldbW", ldbW, 8'h80);
		busTransaction(DEV_WR, `CMD_CLEAR_FAULTS, 8'h00, 8'h00, 1'b0, 6'd18);
		waitStatusBit(3'd5, 1'b0, "statusOut bit 5");
	endtask

	task automatic testAlertMask;
		statusByte_t expStatus;
		expStatus       = '0;
		expStatus.tmpOv = 1'b1;
		busTransaction(DEV_WR, `CMD_SMBALERT_MASK, `CMD_STATUS_TEMPERATURE, 8'h80, 1'b0, 6'd36);
		checkBit("ldbV", sawLdbV, 1'b0);  // legal mask target
		tmpOv = 1'b1;
		stepCycle;
		tmpOv = 1'b0;
		waitStatusBit(3'd2, 1'b1, "statusOut bit 2");
		checkStatus("statusOut", statusByte_t'(statusOut), expStatus);
		repeat (4)
		begin
			stepCycle;
			checkBit("smbAlert", smbAlert, 1'b0);  // masked channel stays quiet
		end
		// 0x55 names no status register
		busTransaction(DEV_WR, `CMD_SMBALERT_MASK, 8'h55, 8'h80, 1'b0, 6'd36);
		checkBit("ldbV", sawLdbV, 1'b1);
	endtask

	task automatic testReadOverrun;
		statusByte_t expStatus;
		expStatus     = '0;
		expStatus.cml = 1'b1;
		busTransaction(DEV_RD, `CMD_READ_VOUT, 8'h00, 8'h00, 1'b1, 6'd36);  // one byte too many
		checkBit("cmlBitOut", sawCml, 1'b1);
		waitStatusBit(3'd1, 1'b1, "statusOut bit 1");
		checkStatus("statusOut", statusByte_t'(statusOut), expStatus);
		busTransaction(DEV_RD, `CMD_STATUS_CML, 8'h00, 8'h00, 1'b1, 6'd27);
		checkByte("ldbW", ldbW, 8'h02);
	endtask

	initial
	begin
		rst = 1'b0;
		{cmd, ldb, hdb, addr} = '0;
		{rwBit, dBusy, start, stop, rStart} = '0;
		count = '0;
		{vout, iout, tmp, vin} = '0;
		{unitOff, voutOv, ioutOc, vinUv, tmpOv, smbalClr} = '0;
		errCount     = 0;
		timeoutCount = 0;
		{sawCmdV, sawLdbV, sawHdbV, sawCml} = '0;

		resetDut;
		testBadCommand;
		resetDut;  // each test starts from a clean block
		testVoutCommand;
		resetDut;
		testTelemetryFreeze;
		resetDut;
		testVoutFault;
		resetDut;
		testAlertMask;
		resetDut;
		testReadOverrun;

		$display("summary: %0d wrong values, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- pmbusRegs.f
+incdir+source
source/pmbusPkg.sv
source/busEventIf.sv
source/protocolChecker.sv
source/faultTracker.sv
source/faultBank.sv
source/responseRegs.sv
source/pmbusRegs.sv
bench/pmbusRegsTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the pmbusRegs testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module pmbusRegsTb -Mdir obj_dir -f pmbusRegs.f
./obj_dir/VpmbusRegsTb | tee sim.log

if grep -q "Done: errors found" sim.log
then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
